// ==== Makefile ====
# Verilator build for the EX stage testbench

TOP := ex_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== dv/ex_tb.sv ====
`timescale 1ns/1ps

module ex_tb;

	// ------------------------------------------------------------------------
	// Run length and limits
	// ------------------------------------------------------------------------

	localparam int RESET_CYCLES = 4;
	localparam int N_RTYPE      = 300;
	localparam int N_IMM        = 200;
	localparam int N_BRANCH     = 200;
	localparam int N_DEST       = 150;
	// Vectors plus reset and a few spare cycles
	localparam int TOTAL_CYCLES = RESET_CYCLES + N_RTYPE + N_IMM + N_BRANCH + N_DEST + 8;
	// Twice the nominal run time at 10 ns per cycle
	localparam int TIMEOUT_NS   = TOTAL_CYCLES * 10 * 2;

	logic           clk;
	logic           arst_n;
	ex_pkg::idex_t  id_ex;
	ex_pkg::exmem_t ex_mem;

	integer seed = 32'hc593;
	int     test_errs;
	int     vec_count;
	int     tests_passed;
	int     tests_failed;
	string  test_name;

	// Funct codes the R-type test picks from
	logic [5:0] funct_list [8] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h27, 6'h2A, 6'h00, 6'h02};

	ex_stage u_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.id_ex  (id_ex),
		.ex_mem (ex_mem)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Reference model and stimulus helpers
	// ------------------------------------------------------------------------

	function automatic logic [31:0] rand32();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	// EX/MEM word expected one cycle after w is presented
	function automatic ex_pkg::exmem_t expected_exmem(input ex_pkg::idex_t w);
		logic [31:0]    raw;
		logic [31:0]    sext;
		logic [31:0]    zext;
		logic [31:0]    b;
		logic [31:0]    res;
		ex_pkg::exmem_t e;
		raw  = w.instr;
		sext = {{16{raw[15]}}, raw[15:0]};
		zext = {16'h0000, raw[15:0]};
		// Operand B, ORI zero-extends
		if (!w.ex.alu_src) begin
			b = w.data_2;
		end else if (w.ex.alu_op == 2'd3) begin
			b = zext;
		end else begin
			b = sext;
		end
		case (w.ex.alu_op)
			2'd0: res = w.data_1 + b;
			2'd1: res = w.data_1 - b;
			2'd3: res = w.data_1 | b;
			default: begin
				case (raw[5:0])
					6'h20:   res = w.data_1 + b;
					6'h22:   res = w.data_1 - b;
					6'h24:   res = w.data_1 & b;
					6'h25:   res = w.data_1 | b;
					6'h27:   res = ~(w.data_1 | b);
					6'h2A:   res = ($signed(w.data_1) < $signed(b)) ? 32'd1 : 32'd0;
					// Shifts by shamt on the rt value
					6'h00:   res = w.data_2 << raw[10:6];
					6'h02:   res = w.data_2 >> raw[10:6];
					default: res = 32'd0;
				endcase
			end
		endcase
		e.alu_result     = res;
		e.zero           = (res == 32'd0);
		e.branch_taken   = w.m.branch & e.zero;
		// Word offset times four from the next pc
		e.target         = w.pc_plus4 + sext * 32'd4;
		e.store_data     = w.data_2;
		e.write_register = w.ex.reg_dst ? raw[15:11] : raw[20:16];
		e.m              = w.m;
		e.wb             = w.wb;
		return e;
	endfunction

	// Fully random ID/EX word, pc word aligned
	function automatic ex_pkg::idex_t random_idex();
		ex_pkg::idex_t w;
		logic [31:0]   r;
		r          = rand32();
		w.pc_plus4 = {r[31:2], 2'b00};
		w.data_1   = rand32();
		w.data_2   = rand32();
		w.instr    = rand32();
		r          = rand32();
		w.ex       = r[3:0];
		w.m        = r[6:4];
		w.wb       = r[8:7];
		return w;
	endfunction

	// ------------------------------------------------------------------------
	// Checking
	// ------------------------------------------------------------------------

	task automatic compare_field(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic compare_exmem(input ex_pkg::exmem_t exp);
		compare_field("target", exp.target, ex_mem.target);
		compare_field("alu_result", exp.alu_result, ex_mem.alu_result);
		compare_field("zero", {31'b0, exp.zero}, {31'b0, ex_mem.zero});
		compare_field("branch_taken", {31'b0, exp.branch_taken},
			{31'b0, ex_mem.branch_taken});
		compare_field("store_data", exp.store_data, ex_mem.store_data);
		compare_field("write_register", {27'b0, exp.write_register},
			{27'b0, ex_mem.write_register});
		compare_field("m", {29'b0, exp.m}, {29'b0, ex_mem.m});
		compare_field("wb", {30'b0, exp.wb}, {30'b0, ex_mem.wb});
	endtask

	// Present w now, check just after the next edge
	task automatic apply_and_check(input ex_pkg::idex_t w);
		ex_pkg::exmem_t exp;
		exp   = expected_exmem(w);
		id_ex = w;
		@(posedge clk);
		#1;
		compare_exmem(exp);
		vec_count++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
		vec_count = 0;
	endtask

	task automatic finish_test();
		$display("test %s: %0d words checked, %0d errors", test_name, vec_count, test_errs);
		if (test_errs == 0) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------

	initial begin
		ex_pkg::idex_t w;
		logic [31:0]   r;
		logic [31:0]   raw;
		tests_passed = 0;
		tests_failed = 0;
		arst_n       = 1'b0;
		id_ex        = random_idex();

		// Reset, register stays clear whatever id_ex holds
		start_test("reset");
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#1;
			compare_exmem('0);
			vec_count++;
			id_ex = random_idex();
		end
		arst_n = 1'b1;
		// Nothing loaded yet right after release
		compare_exmem('0);
		vec_count++;
		finish_test();

		// R-type by funct, rs equal to rt now and then
		start_test("rtype_alu");
		for (int i = 0; i < N_RTYPE; i++) begin
			w            = random_idex();
			r            = rand32();
			w.ex.alu_op  = 2'd2;
			w.ex.alu_src = 1'b0;
			w.ex.reg_dst = 1'b1;
			raw          = w.instr;
			raw[5:0]     = funct_list[r[2:0]];
			// Occasional funct outside the list
			if (r[7:4] == 4'd0) begin
				raw[5:0] = 6'h21;
			end
			if (r[9:8] == 2'd0) begin
				w.data_2 = w.data_1;
			end
			w.instr = raw;
			apply_and_check(w);
		end
		finish_test();

		// Immediate operand, ORI weighted double
		start_test("imm_ops");
		for (int i = 0; i < N_IMM; i++) begin
			w            = random_idex();
			r            = rand32();
			w.ex.alu_src = 1'b1;
			w.ex.reg_dst = 1'b0;
			w.ex.alu_op  = (r[1:0] == 2'd2) ? 2'd3 : r[1:0];
			// rs equal to the immediate so subtracts reach zero
			if (r[4:3] == 2'd0) begin
				raw      = w.instr;
				w.data_1 = {{16{raw[15]}}, raw[15:0]};
			end
			apply_and_check(w);
		end
		finish_test();

		// BEQ style compare, half of them equal
		start_test("branch");
		for (int i = 0; i < N_BRANCH; i++) begin
			w            = random_idex();
			r            = rand32();
			w.ex.alu_op  = 2'd1;
			w.ex.alu_src = 1'b0;
			w.ex.reg_dst = 1'b0;
			w.m          = 3'b100;
			w.wb         = 2'b00;
			if (r[0]) begin
				w.data_2 = w.data_1;
			end
			apply_and_check(w);
		end
		finish_test();

		// Random control with bubbles mixed in
		start_test("dest_pass");
		for (int i = 0; i < N_DEST; i++) begin
			w = random_idex();
			r = rand32();
			if (r[1:0] == 2'd0) begin
				w.ex = '0;
				w.m  = '0;
				w.wb = '0;
			end
			apply_and_check(w);
		end
		finish_test();

		// Reset pulled between edges clears the register at once
		start_test("async_reset");
		#2;
		arst_n = 1'b0;
		#1;
		compare_exmem('0);
		vec_count++;
		finish_test();

		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== src/ex_alu.sv ====
`timescale 1ns/1ps

module ex_alu (
	input  ex_pkg::idex_t    id_ex,
	output ex_pkg::alu_res_t alu_res
);

	logic [31:0] imm_ext;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [3:0]  alu_fn;
	logic [4:0]  shamt;
	logic [31:0] result;

	// ------------------------------------------------------------------------
	// Operand selection
	// ------------------------------------------------------------------------

	// ORI takes the immediate zero-extended
	always_comb begin
		if (id_ex.ex.alu_op == ex_pkg::ALU_OP_ORI) begin
			imm_ext = {16'h0000, id_ex.instr.i_fmt.imm};
		end else begin
			imm_ext = {{16{id_ex.instr.i_fmt.imm[15]}}, id_ex.instr.i_fmt.imm};
		end
	end

	assign op_a = id_ex.data_1;

	// Second operand mux
	assign op_b = id_ex.ex.alu_src ? imm_ext : id_ex.data_2;

	// Shift amount from the R view
	assign shamt = id_ex.instr.r_fmt.shamt;

	// ------------------------------------------------------------------------
	// ALU control
	// ------------------------------------------------------------------------

	always_comb begin
		alu_fn = ex_pkg::ALU_FN_NONE;
		case (id_ex.ex.alu_op)
			ex_pkg::ALU_OP_ADD: alu_fn = ex_pkg::ALU_FN_ADD;
			ex_pkg::ALU_OP_SUB: alu_fn = ex_pkg::ALU_FN_SUB;
			ex_pkg::ALU_OP_ORI: alu_fn = ex_pkg::ALU_FN_OR;
			ex_pkg::ALU_OP_RTYPE: begin
				// R-type, funct picks the operation
				case (id_ex.instr.r_fmt.funct)
					ex_pkg::FUNCT_ADD: alu_fn = ex_pkg::ALU_FN_ADD;
					ex_pkg::FUNCT_SUB: alu_fn = ex_pkg::ALU_FN_SUB;
					ex_pkg::FUNCT_AND: alu_fn = ex_pkg::ALU_FN_AND;
					ex_pkg::FUNCT_OR:  alu_fn = ex_pkg::ALU_FN_OR;
					ex_pkg::FUNCT_NOR: alu_fn = ex_pkg::ALU_FN_NOR;
					ex_pkg::FUNCT_SLT: alu_fn = ex_pkg::ALU_FN_SLT;
					ex_pkg::FUNCT_SLL: alu_fn = ex_pkg::ALU_FN_SLL;
					ex_pkg::FUNCT_SRL: alu_fn = ex_pkg::ALU_FN_SRL;
					// Unknown funct
					default:           alu_fn = ex_pkg::ALU_FN_NONE;
				endcase
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// ALU
	// ------------------------------------------------------------------------

	always_comb begin
		result = 32'h0000_0000;
		case (alu_fn)
			ex_pkg::ALU_FN_ADD: result = op_a + op_b;
			ex_pkg::ALU_FN_SUB: result = op_a - op_b;
			ex_pkg::ALU_FN_AND: result = op_a & op_b;
			ex_pkg::ALU_FN_OR:  result = op_a | op_b;
			ex_pkg::ALU_FN_NOR: result = ~(op_a | op_b);
			// Signed compare, one bit result
			ex_pkg::ALU_FN_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
			// Shifts act on rt's value
			ex_pkg::ALU_FN_SLL: result = id_ex.data_2 << shamt;
			ex_pkg::ALU_FN_SRL: result = id_ex.data_2 >> shamt;
			default:            result = 32'h0000_0000;
		endcase
	end

	// Result and zero flag out
	assign alu_res.result = result;
	assign alu_res.zero   = (result == 32'h0000_0000);

endmodule

// ==== src/ex_branch.sv ====
`timescale 1ns/1ps

module ex_branch (
	input  ex_pkg::idex_t   id_ex,
	output ex_pkg::br_res_t br_res
);

	logic [31:0] imm_sext;
	logic [31:0] offset;
	logic [4:0]  rt;
	logic [4:0]  rd;

	// ------------------------------------------------------------------------
	// Branch target
	// ------------------------------------------------------------------------

	// Branch offset is always signed
	assign imm_sext = {{16{id_ex.instr.i_fmt.imm[15]}}, id_ex.instr.i_fmt.imm};

	// Word offset to byte offset
	assign offset = {imm_sext[29:0], 2'b00};

	// Relative to the next instruction
	assign br_res.target = id_ex.pc_plus4 + offset;

	// ------------------------------------------------------------------------
	// Destination register
	// ------------------------------------------------------------------------

	// rt sits at the same bits in both views
	assign rt = id_ex.instr.i_fmt.rt;
	// rd only exists in the R view
	assign rd = id_ex.instr.r_fmt.rd;

	// R-type writes rd, loads and immediates write rt
	always_comb begin
		if (id_ex.ex.reg_dst) begin
			br_res.write_register = rd;
		end else begin
			br_res.write_register = rt;
		end
	end

endmodule

// ==== src/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg (
	input  logic             clk,
	input  logic             arst_n,
	input  ex_pkg::idex_t    id_ex,
	input  ex_pkg::alu_res_t alu_res,
	input  ex_pkg::br_res_t  br_res,
	output ex_pkg::exmem_t   ex_mem
);

	ex_pkg::exmem_t ex_mem_d;

	// ------------------------------------------------------------------------
	// Next EX/MEM word
	// ------------------------------------------------------------------------

	always_comb begin
		// Results from the two parallel blocks
		ex_mem_d.target         = br_res.target;
		ex_mem_d.write_register = br_res.write_register;
		ex_mem_d.alu_result     = alu_res.result;
		ex_mem_d.zero           = alu_res.zero;

		// Taken when a branch compares equal
		ex_mem_d.branch_taken   = id_ex.m.branch & alu_res.zero;

		// Value for a store
		ex_mem_d.store_data     = id_ex.data_2;

		// Later stage control goes through as is
		ex_mem_d.m              = id_ex.m;
		ex_mem_d.wb             = id_ex.wb;
	end

	// ------------------------------------------------------------------------
	// Pipeline register
	// ------------------------------------------------------------------------

	// Loads every cycle, no stall at this point
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// All zero acts as a bubble
			ex_mem <= '0;
		end else begin
			ex_mem <= ex_mem_d;
		end
	end

endmodule

// ==== src/ex_pkg.sv ====
package ex_pkg;

	// ------------------------------------------------------------------------
	// Instruction word views
	// ------------------------------------------------------------------------

	// R-format fields
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	// I-format fields
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	// Same 32 bits read either way
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_u;

	// ------------------------------------------------------------------------
	// Control fields
	// ------------------------------------------------------------------------

	// EX bits, reg_dst on bit 3 and alu_src on bit 0
	typedef struct packed {
		logic       reg_dst;
		logic [1:0] alu_op;
		logic       alu_src;
	} ex_ctrl_t;

	// Memory stage bits
	typedef struct packed {
		logic branch;
		logic mem_read;
		logic mem_write;
	} m_ctrl_t;

	// Write-back bits
	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	// alu_op encodings
	localparam logic [1:0] ALU_OP_ADD   = 2'd0;
	localparam logic [1:0] ALU_OP_SUB   = 2'd1;
	localparam logic [1:0] ALU_OP_RTYPE = 2'd2;
	localparam logic [1:0] ALU_OP_ORI   = 2'd3;

	// R-type funct codes
	localparam logic [5:0] FUNCT_ADD = 6'h20;
	localparam logic [5:0] FUNCT_SUB = 6'h22;
	localparam logic [5:0] FUNCT_AND = 6'h24;
	localparam logic [5:0] FUNCT_OR  = 6'h25;
	localparam logic [5:0] FUNCT_NOR = 6'h27;
	localparam logic [5:0] FUNCT_SLT = 6'h2A;
	localparam logic [5:0] FUNCT_SLL = 6'h00;
	localparam logic [5:0] FUNCT_SRL = 6'h02;

	// Internal ALU function select
	localparam logic [3:0] ALU_FN_NONE = 4'd0;
	localparam logic [3:0] ALU_FN_ADD  = 4'd1;
	localparam logic [3:0] ALU_FN_SUB  = 4'd2;
	localparam logic [3:0] ALU_FN_AND  = 4'd3;
	localparam logic [3:0] ALU_FN_OR   = 4'd4;
	localparam logic [3:0] ALU_FN_NOR  = 4'd5;
	localparam logic [3:0] ALU_FN_SLT  = 4'd6;
	localparam logic [3:0] ALU_FN_SLL  = 4'd7;
	localparam logic [3:0] ALU_FN_SRL  = 4'd8;

	// ------------------------------------------------------------------------
	// Pipeline words
	// ------------------------------------------------------------------------

	// ID/EX register contents
	typedef struct packed {
		logic [31:0] pc_plus4;
		logic [31:0] data_1;
		logic [31:0] data_2;
		instr_u      instr;
		ex_ctrl_t    ex;
		m_ctrl_t     m;
		wb_ctrl_t    wb;
	} idex_t;

	// ALU output
	typedef struct packed {
		logic [31:0] result;
		logic        zero;
	} alu_res_t;

	// Branch block output
	typedef struct packed {
		logic [31:0] target;
		logic [4:0]  write_register;
	} br_res_t;

	// EX/MEM register contents
	typedef struct packed {
		logic [31:0] target;
		logic [31:0] alu_result;
		logic        zero;
		logic        branch_taken;
		logic [31:0] store_data;
		logic [4:0]  write_register;
		m_ctrl_t     m;
		wb_ctrl_t    wb;
	} exmem_t;

endpackage

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
	input  logic           clk,
	input  logic           arst_n,
	input  ex_pkg::idex_t  id_ex,
	output ex_pkg::exmem_t ex_mem
);

	// ------------------------------------------------------------------------
	// Internal results
	// ------------------------------------------------------------------------

	// ALU result and zero flag
	ex_pkg::alu_res_t alu_res;
	// Branch target and destination register
	ex_pkg::br_res_t  br_res;

	// ------------------------------------------------------------------------
	// Combinational blocks
	// ------------------------------------------------------------------------

	// Operand mux, ALU control and ALU
	ex_alu u_alu (
		.id_ex   (id_ex),
		.alu_res (alu_res)
	);

	// Target adder and rt/rd mux
	ex_branch u_branch (
		.id_ex  (id_ex),
		.br_res (br_res)
	);

	// ------------------------------------------------------------------------
	// EX/MEM register
	// ------------------------------------------------------------------------

	// One cycle from id_ex to ex_mem
	ex_mem_reg u_ex_mem (
		.clk     (clk),
		.arst_n  (arst_n),
		.id_ex   (id_ex),
		.alu_res (alu_res),
		.br_res  (br_res),
		.ex_mem  (ex_mem)
	);

endmodule

// ==== tb.f ====
src/ex_pkg.sv
src/ex_alu.sv
src/ex_branch.sv
src/ex_mem_reg.sv
src/ex_stage.sv
dv/ex_tb.sv
